/* compile.f */
+incdir+hw
hw/id_pkg.sv
hw/inst_decoder.sv
hw/imm_gen.sv
hw/operand_fwd.sv
hw/id_stage.sv
verif/id_stage_properties.sv
verif/id_stage_tb.sv

/* hw/id_defines.svh */
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// widths
`define REG_W        32
`define REG_ADDR_W   5
`define INST_W       32

`define NOP_REG_ADDR 5'b00000

// major opcodes, inst[31:26]
`define OP_SPECIAL   6'b000000
`define OP_ORI       6'b001101
`define OP_ANDI      6'b001100
`define OP_XORI      6'b001110
`define OP_LUI       6'b001111
`define OP_ADDI      6'b001000
`define OP_ADDIU     6'b001001
`define OP_SLTI      6'b001010
`define OP_SLTIU     6'b001011

// SPECIAL function codes, inst[5:0]
`define FN_OR        6'b100101
`define FN_AND       6'b100100
`define FN_XOR       6'b100110
`define FN_NOR       6'b100111
`define FN_SLL       6'b000000
`define FN_SRL       6'b000010
`define FN_SRA       6'b000011
`define FN_SLLV      6'b000100
`define FN_SRLV      6'b000110
`define FN_SRAV      6'b000111
`define FN_ADD       6'b100000
`define FN_ADDU      6'b100001
`define FN_SUB       6'b100010
`define FN_SUBU      6'b100011
`define FN_SLT       6'b101010
`define FN_SLTU      6'b101011

`endif

/* hw/id_pkg.sv */
`default_nettype none

`include "id_defines.svh"

package id_pkg;

    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        ALU_OR    = 8'b0010_0101,
        ALU_AND   = 8'b0010_0100,
        ALU_XOR   = 8'b0010_0110,
        ALU_NOR   = 8'b0010_0111,
        ALU_SLL   = 8'b0111_1100,
        ALU_SRL   = 8'b0000_0010,
        ALU_SRA   = 8'b0000_0011,
        ALU_ADD   = 8'b0010_0000,
        ALU_ADDU  = 8'b0010_0001,
        ALU_ADDI  = 8'b0101_0101,
        ALU_ADDIU = 8'b0101_0110,
        ALU_SUB   = 8'b0010_0010,
        ALU_SUBU  = 8'b0010_0011,
        ALU_SLT   = 8'b0010_1010,
        ALU_SLTU  = 8'b0010_1011
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alusel_e;

    typedef enum logic [1:0] {
        IMM_ZERO_EXT = 2'd0,
        IMM_SIGN_EXT = 2'd1,
        IMM_UPPER    = 2'd2,
        IMM_SHAMT    = 2'd3
    } imm_kind_e;

    typedef struct packed {
        aluop_e                 aluop;
        alusel_e                alusel;
        imm_kind_e              imm_kind;
        logic                   reg1_ren;
        logic                   reg2_ren;
        logic                   wreg;
        logic [`REG_ADDR_W-1:0] waddr;
        logic                   inst_valid;
    } dec_ctrl_t;

    // pending write of a later stage
    typedef struct packed {
        logic                   wreg;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`REG_W-1:0]      wdata;
    } wb_fwd_t;

    typedef struct packed {
        aluop_e                 aluop;
        alusel_e                alusel;
        logic [`REG_W-1:0]      reg1_data;
        logic [`REG_W-1:0]      reg2_data;
        logic [`REG_ADDR_W-1:0] waddr;
        logic                   wreg;
        logic                   inst_valid;
    } id_ex_t;

endpackage

`default_nettype wire

/* hw/id_stage.sv */
`default_nettype none
`timescale 1ns/10ps

`include "id_defines.svh"

module id_stage (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic [`INST_W-1:0]     inst_i,
    input  id_pkg::wb_fwd_t        ex_fwd_i,
    input  id_pkg::wb_fwd_t        mem_fwd_i,
    input  logic [`REG_W-1:0]      reg1_data_i,
    input  logic [`REG_W-1:0]      reg2_data_i,
    output logic [`REG_ADDR_W-1:0] reg1_addr_o,
    output logic                   reg1_ren_o,
    output logic [`REG_ADDR_W-1:0] reg2_addr_o,
    output logic                   reg2_ren_o,
    output id_pkg::id_ex_t         id_ex_o
);

    localparam id_pkg::id_ex_t ID_EX_RST = '{
        aluop:      id_pkg::ALU_NOP,
        alusel:     id_pkg::SEL_NOP,
        reg1_data:  '0,
        reg2_data:  '0,
        waddr:      `NOP_REG_ADDR,
        wreg:       1'b0,
        inst_valid: 1'b0
    };

    id_pkg::dec_ctrl_t  ctrl;
    logic [`REG_W-1:0]  imm;
    id_pkg::id_ex_t     id_ex_d;

    inst_decoder i_dec (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    imm_gen i_imm (
        .inst_i     (inst_i),
        .imm_kind_i (ctrl.imm_kind),
        .imm_o      (imm)
    );

    // regfile read side, same cycle
    assign reg1_addr_o = inst_i[25:21];
    assign reg2_addr_o = inst_i[20:16];
    assign reg1_ren_o  = ctrl.reg1_ren;
    assign reg2_ren_o  = ctrl.reg2_ren;

    operand_fwd i_fwd_rs (
        .ren_i     (ctrl.reg1_ren),
        .raddr_i   (reg1_addr_o),
        .rf_data_i (reg1_data_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (id_ex_d.reg1_data)
    );

    operand_fwd i_fwd_rt (
        .ren_i     (ctrl.reg2_ren),
        .raddr_i   (reg2_addr_o),
        .rf_data_i (reg2_data_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (id_ex_d.reg2_data)
    );

    assign id_ex_d.aluop      = ctrl.aluop;
    assign id_ex_d.alusel     = ctrl.alusel;
    assign id_ex_d.waddr      = ctrl.waddr;
    assign id_ex_d.wreg       = ctrl.wreg;
    assign id_ex_d.inst_valid = ctrl.inst_valid;

    // ID/EX pipeline register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= ID_EX_RST;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

/* hw/imm_gen.sv */
`default_nettype none
`timescale 1ns/10ps

`include "id_defines.svh"

module imm_gen (
    input  logic [`INST_W-1:0] inst_i,
    input  id_pkg::imm_kind_e  imm_kind_i,
    output logic [`REG_W-1:0]  imm_o
);

    logic [15:0] imm16;

    assign imm16 = inst_i[15:0];

    always_comb begin
        case (imm_kind_i)
            id_pkg::IMM_ZERO_EXT:
                imm_o = {{(`REG_W-16){1'b0}}, imm16};
            id_pkg::IMM_SIGN_EXT:
                imm_o = {{(`REG_W-16){imm16[15]}}, imm16};
            id_pkg::IMM_UPPER:
                imm_o = {imm16, {(`REG_W-16){1'b0}}}; // lui
            id_pkg::IMM_SHAMT:
                imm_o = {{(`REG_W-5){1'b0}}, inst_i[10:6]};
            default:
                imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/inst_decoder.sv */
`default_nettype none
`timescale 1ns/10ps

`include "id_defines.svh"

module inst_decoder (
    input  logic [`INST_W-1:0] inst_i,
    output id_pkg::dec_ctrl_t  ctrl_o
);

    logic [5:0]             opcode;
    logic [5:0]             funct;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [4:0]             shamt;
    logic                   imm_op;
    logic                   const_shift;

    assign opcode = inst_i[31:26];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = inst_i[5:0];

    assign imm_op = opcode inside {`OP_ORI, `OP_ANDI, `OP_XORI, `OP_LUI,
                                   `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU};

    // sll/srl/sra, op and rs all zero
    assign const_shift = (inst_i[31:21] == 11'd0) &&
                         (funct inside {`FN_SLL, `FN_SRL, `FN_SRA});

    always_comb begin
        ctrl_o.aluop      = id_pkg::ALU_NOP;
        ctrl_o.alusel     = id_pkg::SEL_NOP;
        ctrl_o.imm_kind   = id_pkg::IMM_ZERO_EXT;
        ctrl_o.reg1_ren   = 1'b0;
        ctrl_o.reg2_ren   = 1'b0;
        ctrl_o.wreg       = 1'b0;
        ctrl_o.waddr      = rd;
        ctrl_o.inst_valid = 1'b0;

        if (opcode == `OP_SPECIAL && shamt == 5'd0) begin
            ctrl_o.inst_valid = 1'b1;
            case (funct)
                `FN_OR, `FN_AND, `FN_XOR, `FN_NOR:
                    ctrl_o.alusel = id_pkg::SEL_LOGIC;
                `FN_SLLV, `FN_SRLV, `FN_SRAV:
                    ctrl_o.alusel = id_pkg::SEL_SHIFT;
                `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_SLT, `FN_SLTU:
                    ctrl_o.alusel = id_pkg::SEL_ARITH;
                default:
                    ctrl_o.inst_valid = 1'b0; // hi/lo, mult, movn/movz, sync
            endcase
            case (funct)
                `FN_OR:   ctrl_o.aluop = id_pkg::ALU_OR;
                `FN_AND:  ctrl_o.aluop = id_pkg::ALU_AND;
                `FN_XOR:  ctrl_o.aluop = id_pkg::ALU_XOR;
                `FN_NOR:  ctrl_o.aluop = id_pkg::ALU_NOR;
                `FN_SLLV: ctrl_o.aluop = id_pkg::ALU_SLL;
                `FN_SRLV: ctrl_o.aluop = id_pkg::ALU_SRL;
                `FN_SRAV: ctrl_o.aluop = id_pkg::ALU_SRA;
                `FN_ADD:  ctrl_o.aluop = id_pkg::ALU_ADD;
                `FN_ADDU: ctrl_o.aluop = id_pkg::ALU_ADDU;
                `FN_SUB:  ctrl_o.aluop = id_pkg::ALU_SUB;
                `FN_SUBU: ctrl_o.aluop = id_pkg::ALU_SUBU;
                `FN_SLT:  ctrl_o.aluop = id_pkg::ALU_SLT;
                `FN_SLTU: ctrl_o.aluop = id_pkg::ALU_SLTU;
                default:  ctrl_o.aluop = id_pkg::ALU_NOP;
            endcase
            ctrl_o.reg1_ren = ctrl_o.inst_valid;
            ctrl_o.reg2_ren = ctrl_o.inst_valid;
            ctrl_o.wreg     = ctrl_o.inst_valid;
        end

        if (imm_op) begin
            case (opcode)
                `OP_ORI, `OP_ANDI, `OP_XORI: begin
                    ctrl_o.alusel   = id_pkg::SEL_LOGIC;
                    ctrl_o.imm_kind = id_pkg::IMM_ZERO_EXT;
                end
                `OP_LUI: begin
                    ctrl_o.alusel   = id_pkg::SEL_LOGIC;
                    ctrl_o.imm_kind = id_pkg::IMM_UPPER;
                end
                default: begin
                    ctrl_o.alusel   = id_pkg::SEL_ARITH;
                    ctrl_o.imm_kind = id_pkg::IMM_SIGN_EXT;
                end
            endcase
            case (opcode)
                `OP_ORI:   ctrl_o.aluop = id_pkg::ALU_OR;
                `OP_LUI:   ctrl_o.aluop = id_pkg::ALU_OR;  // imm already shifted up
                `OP_ANDI:  ctrl_o.aluop = id_pkg::ALU_AND;
                `OP_XORI:  ctrl_o.aluop = id_pkg::ALU_XOR;
                `OP_ADDI:  ctrl_o.aluop = id_pkg::ALU_ADDI;
                `OP_ADDIU: ctrl_o.aluop = id_pkg::ALU_ADDIU;
                `OP_SLTI:  ctrl_o.aluop = id_pkg::ALU_SLT;
                default:   ctrl_o.aluop = id_pkg::ALU_SLTU;
            endcase
            ctrl_o.reg1_ren   = 1'b1;
            ctrl_o.wreg       = 1'b1;
            ctrl_o.waddr      = rt;
            ctrl_o.inst_valid = 1'b1;
        end

        // constant shifts win over the opcode decode
        if (const_shift) begin
            ctrl_o.alusel     = id_pkg::SEL_SHIFT;
            ctrl_o.imm_kind   = id_pkg::IMM_SHAMT;
            ctrl_o.reg1_ren   = 1'b0;             // port 1 carries shamt
            ctrl_o.reg2_ren   = 1'b1;
            ctrl_o.wreg       = 1'b1;
            ctrl_o.waddr      = rd;
            ctrl_o.inst_valid = 1'b1;
            case (funct)
                `FN_SLL: ctrl_o.aluop = id_pkg::ALU_SLL;
                `FN_SRL: ctrl_o.aluop = id_pkg::ALU_SRL;
                default: ctrl_o.aluop = id_pkg::ALU_SRA;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/operand_fwd.sv */
`default_nettype none
`timescale 1ns/10ps

`include "id_defines.svh"

module operand_fwd (
    input  logic                   ren_i,
    input  logic [`REG_ADDR_W-1:0] raddr_i,
    input  logic [`REG_W-1:0]      rf_data_i,
    input  logic [`REG_W-1:0]      imm_i,
    input  id_pkg::wb_fwd_t        ex_fwd_i,
    input  id_pkg::wb_fwd_t        mem_fwd_i,
    output logic [`REG_W-1:0]      operand_o
);

    logic ex_hit;
    logic mem_hit;

    // r0 not excluded
    assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.waddr == raddr_i);
    assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.waddr == raddr_i);

    always_comb begin
        if (!ren_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.wdata;   // youngest result first
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire

/* verif/id_stage_properties.sv */
`default_nettype none
`timescale 1ns/10ps

module id_stage_properties (
    input logic           clk,
    input logic           arst_n_i,
    input id_pkg::id_ex_t id_ex_i
);

    int fail_cnt = 0;

    // first edge after release still sees the cleared bundle
    a_reset_state: assert property (@(posedge clk) $rose(arst_n_i) |->
        (!id_ex_i.wreg && !id_ex_i.inst_valid && id_ex_i.aluop == id_pkg::ALU_NOP &&
         id_ex_i.alusel == id_pkg::SEL_NOP && id_ex_i.waddr == '0 &&
         id_ex_i.reg1_data == '0 && id_ex_i.reg2_data == '0))
    else begin
        $error("id_ex not in reset state after reset release");
        fail_cnt = fail_cnt + 1;
    end

    a_wreg_valid: assert property (@(posedge clk) id_ex_i.wreg |-> id_ex_i.inst_valid)
    else begin
        $error("wreg set on an invalid instruction");
        fail_cnt = fail_cnt + 1;
    end

    a_invalid_nop: assert property (@(posedge clk) !id_ex_i.inst_valid |->
        (id_ex_i.aluop == id_pkg::ALU_NOP && !id_ex_i.wreg))
    else begin
        $error("invalid instruction with non-NOP aluop or wreg");
        fail_cnt = fail_cnt + 1;
    end

endmodule

bind id_stage id_stage_properties i_props (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .id_ex_i  (id_ex_o)
);

`default_nettype wire

/* verif/id_stage_tb.sv */
`default_nettype none
`timescale 1ns/10ps

`include "id_defines.svh"

module id_stage_tb;

    localparam logic [`REG_W-1:0] RF1  = 32'hA5A5_0101;
    localparam logic [`REG_W-1:0] RF2  = 32'h5A5A_0202;
    localparam logic [`REG_W-1:0] EXD  = 32'hE0E0_0003;
    localparam logic [`REG_W-1:0] MEMD = 32'hD0D0_0004;
    localparam id_pkg::wb_fwd_t   NO_FWD = '0;

    typedef struct packed {
        logic [`INST_W-1:0] inst;
        logic [`REG_W-1:0]  rf1;
        logic [`REG_W-1:0]  rf2;
        id_pkg::wb_fwd_t    ex;
        id_pkg::wb_fwd_t    mem;
        logic [4:0]         ra1;
        logic [4:0]         ra2;
        logic               ren1;
        logic               ren2;
        logic               full;   // 0 for invalid ops, control fields only
        id_pkg::id_ex_t     want;
    } vec_t;

    logic                   clk;
    logic                   arst_n_i;
    logic [`INST_W-1:0]     inst_i;
    id_pkg::wb_fwd_t        ex_fwd_i;
    id_pkg::wb_fwd_t        mem_fwd_i;
    logic [`REG_W-1:0]      reg1_data_i;
    logic [`REG_W-1:0]      reg2_data_i;
    logic [`REG_ADDR_W-1:0] reg1_addr_o;
    logic                   reg1_ren_o;
    logic [`REG_ADDR_W-1:0] reg2_addr_o;
    logic                   reg2_ren_o;
    id_pkg::id_ex_t         id_ex_o;

    vec_t vecs[$];
    int   cycles;

    id_stage i_dut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .inst_i      (inst_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .reg1_addr_o (reg1_addr_o),
        .reg1_ren_o  (reg1_ren_o),
        .reg2_addr_o (reg2_addr_o),
        .reg2_ren_o  (reg2_ren_o),
        .id_ex_o     (id_ex_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 10 + vecs.size() + 20) begin
            $display("run timed out after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [`INST_W-1:0] enc_rtype(input logic [4:0] rs, rt, rd, sa,
                                                     input logic [5:0] fn);
        return {`OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [`INST_W-1:0] enc_itype(input logic [5:0] op,
                                                     input logic [4:0] rs, rt,
                                                     input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic id_pkg::wb_fwd_t fwd(input logic we, input logic [4:0] addr,
                                            input logic [`REG_W-1:0] data);
        return {we, addr, data};
    endfunction

    function automatic id_pkg::id_ex_t expect_ex(
        input id_pkg::aluop_e    op,
        input id_pkg::alusel_e   sel,
        input logic [`REG_W-1:0] d1,
        input logic [`REG_W-1:0] d2,
        input logic [4:0]        waddr,
        input logic              valid
    );
        id_pkg::id_ex_t e;
        e.aluop      = op;
        e.alusel     = sel;
        e.reg1_data  = d1;
        e.reg2_data  = d2;
        e.waddr      = waddr;
        e.wreg       = valid;
        e.inst_valid = valid;
        return e;
    endfunction

    task automatic push_vec(input logic [`INST_W-1:0] inst, input id_pkg::wb_fwd_t ex,
                            input id_pkg::wb_fwd_t mem, input logic ren1, input logic ren2,
                            input logic full, input logic [4:0] ra1, input logic [4:0] ra2,
                            input id_pkg::id_ex_t want);
        vec_t v;
        v.inst = inst;
        v.rf1  = RF1;
        v.rf2  = RF2;
        v.ex   = ex;
        v.mem  = mem;
        v.ra1  = ra1;
        v.ra2  = ra2;
        v.ren1 = ren1;
        v.ren2 = ren2;
        v.full = full;
        v.want = want;
        vecs.push_back(v);
    endtask

    // rs=1 rt=2 rd=3, both ports from the register file
    task automatic reg_op(input logic [5:0] fn, input id_pkg::aluop_e op,
                          input id_pkg::alusel_e sel);
        push_vec(enc_rtype(1, 2, 3, 0, fn), NO_FWD, NO_FWD, 1'b1, 1'b1, 1'b1,
                 5'd1, 5'd2, expect_ex(op, sel, RF1, RF2, 5'd3, 1'b1));
    endtask

    task automatic imm_op(input logic [5:0] opc, input logic [15:0] imm,
                          input id_pkg::aluop_e op, input id_pkg::alusel_e sel,
                          input logic [`REG_W-1:0] imm32);
        push_vec(enc_itype(opc, 4, 5, imm), NO_FWD, NO_FWD, 1'b1, 1'b0, 1'b1,
                 5'd4, 5'd5, expect_ex(op, sel, RF1, imm32, 5'd5, 1'b1));
    endtask

    task automatic shift_op(input logic [5:0] fn, input logic [4:0] sa,
                            input id_pkg::aluop_e op);
        push_vec(enc_rtype(0, 6, 7, sa, fn), NO_FWD, NO_FWD, 1'b0, 1'b1, 1'b1,
                 5'd0, 5'd6, expect_ex(op, id_pkg::SEL_SHIFT, {27'd0, sa}, RF2, 5'd7, 1'b1));
    endtask

    task automatic dropped_op(input logic [`INST_W-1:0] inst, input logic [4:0] ra1,
                              input logic [4:0] ra2);
        push_vec(inst, NO_FWD, NO_FWD, 1'b0, 1'b0, 1'b0, ra1, ra2,
                 expect_ex(id_pkg::ALU_NOP, id_pkg::SEL_NOP, '0, '0, 5'd0, 1'b0));
    endtask

    task automatic build_table;
        reg_op(`FN_OR, id_pkg::ALU_OR, id_pkg::SEL_LOGIC);
        reg_op(`FN_AND, id_pkg::ALU_AND, id_pkg::SEL_LOGIC);
        reg_op(`FN_XOR, id_pkg::ALU_XOR, id_pkg::SEL_LOGIC);
        reg_op(`FN_NOR, id_pkg::ALU_NOR, id_pkg::SEL_LOGIC);
        reg_op(`FN_SLLV, id_pkg::ALU_SLL, id_pkg::SEL_SHIFT);
        reg_op(`FN_SRLV, id_pkg::ALU_SRL, id_pkg::SEL_SHIFT);
        reg_op(`FN_SRAV, id_pkg::ALU_SRA, id_pkg::SEL_SHIFT);
        reg_op(`FN_ADD, id_pkg::ALU_ADD, id_pkg::SEL_ARITH);
        reg_op(`FN_ADDU, id_pkg::ALU_ADDU, id_pkg::SEL_ARITH);
        reg_op(`FN_SUB, id_pkg::ALU_SUB, id_pkg::SEL_ARITH);
        reg_op(`FN_SUBU, id_pkg::ALU_SUBU, id_pkg::SEL_ARITH);
        reg_op(`FN_SLT, id_pkg::ALU_SLT, id_pkg::SEL_ARITH);
        reg_op(`FN_SLTU, id_pkg::ALU_SLTU, id_pkg::SEL_ARITH);
        imm_op(`OP_ORI, 16'h8001, id_pkg::ALU_OR, id_pkg::SEL_LOGIC, 32'h0000_8001);
        imm_op(`OP_ANDI, 16'hF00F, id_pkg::ALU_AND, id_pkg::SEL_LOGIC, 32'h0000_F00F);
        imm_op(`OP_XORI, 16'hFFFF, id_pkg::ALU_XOR, id_pkg::SEL_LOGIC, 32'h0000_FFFF);
        imm_op(`OP_LUI, 16'h8765, id_pkg::ALU_OR, id_pkg::SEL_LOGIC, 32'h8765_0000);
        imm_op(`OP_ADDI, 16'h0010, id_pkg::ALU_ADDI, id_pkg::SEL_ARITH, 32'h0000_0010);
        imm_op(`OP_ADDI, 16'h8000, id_pkg::ALU_ADDI, id_pkg::SEL_ARITH, 32'hFFFF_8000);
        imm_op(`OP_ADDIU, 16'h7FFF, id_pkg::ALU_ADDIU, id_pkg::SEL_ARITH, 32'h0000_7FFF);
        imm_op(`OP_SLTI, 16'h0123, id_pkg::ALU_SLT, id_pkg::SEL_ARITH, 32'h0000_0123);
        imm_op(`OP_SLTI, 16'hFFFE, id_pkg::ALU_SLT, id_pkg::SEL_ARITH, 32'hFFFF_FFFE);
        imm_op(`OP_SLTIU, 16'hFFF0, id_pkg::ALU_SLTU, id_pkg::SEL_ARITH, 32'hFFFF_FFF0);
        shift_op(`FN_SLL, 5'd5, id_pkg::ALU_SLL);
        shift_op(`FN_SRL, 5'd31, id_pkg::ALU_SRL);
        shift_op(`FN_SRA, 5'd16, id_pkg::ALU_SRA);
        // forwarding, execute beats memory on rs
        push_vec(enc_rtype(8, 9, 10, 0, `FN_ADD), fwd(1, 8, EXD), fwd(1, 8, MEMD), 1, 1, 1,
                 8, 9, expect_ex(id_pkg::ALU_ADD, id_pkg::SEL_ARITH, EXD, RF2, 5'd10, 1'b1));
        push_vec(enc_rtype(8, 9, 10, 0, `FN_ADD), fwd(1, 11, EXD), fwd(1, 9, MEMD), 1, 1, 1,
                 8, 9, expect_ex(id_pkg::ALU_ADD, id_pkg::SEL_ARITH, RF1, MEMD, 5'd10, 1'b1));
        push_vec(enc_rtype(8, 9, 10, 0, `FN_ADD), fwd(0, 8, EXD), fwd(0, 9, MEMD), 1, 1, 1,
                 8, 9, expect_ex(id_pkg::ALU_ADD, id_pkg::SEL_ARITH, RF1, RF2, 5'd10, 1'b1));
        // rt port unread, imm wins over the matching execute write
        push_vec(enc_itype(`OP_ORI, 8, 9, 16'h1234), fwd(1, 9, EXD), fwd(1, 8, MEMD), 1, 0, 1,
                 8, 9, expect_ex(id_pkg::ALU_OR, id_pkg::SEL_LOGIC, MEMD, 32'h1234, 5'd9, 1'b1));
        dropped_op(enc_rtype(1, 2, 0, 0, 6'b011000), 1, 2);                  // mult
        dropped_op(enc_rtype(0, 0, 3, 0, 6'b010000), 0, 0);                  // mfhi
        dropped_op({6'b011100, 5'd1, 5'd0, 5'd3, 5'd0, 6'b100000}, 1, 0);    // clz
        dropped_op(enc_rtype(1, 2, 3, 0, 6'b001011), 1, 2);                  // movn
        dropped_op(enc_itype(6'b111111, 1, 2, 16'h1234), 1, 2);
    endtask

    task automatic compare(input string name, input logic [127:0] act,
                           input logic [127:0] want);
        if (act !== want) begin
            $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, act, want);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_reads(input vec_t v);
        compare("reg1_addr_o", reg1_addr_o, v.ra1);
        compare("reg1_ren_o", reg1_ren_o, v.ren1);
        compare("reg2_addr_o", reg2_addr_o, v.ra2);
        compare("reg2_ren_o", reg2_ren_o, v.ren2);
    endtask

    task automatic check_ex(input vec_t v);
        compare("id_ex_o.aluop", id_ex_o.aluop, v.want.aluop);
        compare("id_ex_o.alusel", id_ex_o.alusel, v.want.alusel);
        compare("id_ex_o.wreg", id_ex_o.wreg, v.want.wreg);
        compare("id_ex_o.inst_valid", id_ex_o.inst_valid, v.want.inst_valid);
        if (v.full) begin
            compare("id_ex_o.reg1_data", id_ex_o.reg1_data, v.want.reg1_data);
            compare("id_ex_o.reg2_data", id_ex_o.reg2_data, v.want.reg2_data);
            compare("id_ex_o.waddr", id_ex_o.waddr, v.want.waddr);
        end
    endtask

    initial begin
        vec_t v;
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        inst_i      = '0;
        ex_fwd_i    = '0;
        mem_fwd_i   = '0;
        reg1_data_i = '0;
        reg2_data_i = '0;
        build_table();

        repeat (10) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        compare("id_ex_o.wreg", id_ex_o.wreg, 1'b0);
        compare("id_ex_o.inst_valid", id_ex_o.inst_valid, 1'b0);
        compare("id_ex_o.aluop", id_ex_o.aluop, id_pkg::ALU_NOP);
        compare("id_ex_o.alusel", id_ex_o.alusel, id_pkg::SEL_NOP);

        // one entry per cycle, id_ex_o lags by one edge
        for (int i = 0; i <= vecs.size(); i++) begin
            @(posedge clk);
            if (i < vecs.size()) begin
                v = vecs[i];
                inst_i      <= v.inst;
                reg1_data_i <= v.rf1;
                reg2_data_i <= v.rf2;
                ex_fwd_i    <= v.ex;
                mem_fwd_i   <= v.mem;
            end
            @(negedge clk);
            if (i < vecs.size()) begin
                check_reads(v);
            end
            if (i > 0) begin
                check_ex(vecs[i-1]);
            end
        end

        if (i_dut.i_props.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("%0d assertion failure(s) on id_ex_o", i_dut.i_props.fail_cnt);
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failure");
        end
    end

endmodule

`default_nettype wire
